// ==== rtl/serial_core_pkg.sv ====
`default_nettype none

package serial_core_pkg;

   localparam int XLEN = 32;

   // Major opcodes handled by the core
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // ALU operation select
   localparam logic [2:0] ALU_ADD  = 3'd0;
   localparam logic [2:0] ALU_SUB  = 3'd1;
   localparam logic [2:0] ALU_AND  = 3'd2;
   localparam logic [2:0] ALU_OR   = 3'd3;
   localparam logic [2:0] ALU_XOR  = 3'd4;
   localparam logic [2:0] ALU_SLT  = 3'd5;
   localparam logic [2:0] ALU_SLTU = 3'd6;

   // Same instruction word seen as R-type or I-type
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
   } insn_u;

endpackage

`default_nettype wire

// ==== rtl/core_state.sv ====
`default_nettype none
`timescale 1ns/1ps

module core_state #(
   parameter int          W        = 1,
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  wire         clk,
   input  wire         i_rst_n,
   input  wire         i_ibus_ack,
   output logic        o_ibus_cyc,
   output logic [31:0] o_ibus_adr,
   output logic        o_latch,
   output logic        o_load,
   output logic        o_run,
   output logic        o_first,
   output logic        o_rtr_valid,
   output logic [31:0] o_rtr_pc
);

   localparam int N  = serial_core_pkg::XLEN / W;
   localparam int CW = $clog2(N);

   localparam logic [1:0] PH_FETCH  = 2'd0;
   localparam logic [1:0] PH_LOAD   = 2'd1;
   localparam logic [1:0] PH_RUN    = 2'd2;
   localparam logic [1:0] PH_RETIRE = 2'd3;

   logic [1:0]                         phase;
   logic [CW-1:0]                      cnt;
   logic [serial_core_pkg::XLEN-1:0]   pc;
   logic [serial_core_pkg::XLEN-1:0]   rtr_pc;
   logic                               last;

   // Next fetch already requested while the retire record is out
   assign o_ibus_cyc  = (phase == PH_FETCH) || (phase == PH_RETIRE);
   assign o_ibus_adr  = pc;
   assign o_latch     = o_ibus_cyc && i_ibus_ack;
   assign o_load      = (phase == PH_LOAD);
   assign o_run       = (phase == PH_RUN);
   assign o_first     = o_run && (cnt == '0);
   assign last        = o_run && (cnt == CW'(N - 1));
   assign o_rtr_valid = (phase == PH_RETIRE);
   assign o_rtr_pc    = rtr_pc;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase  <= PH_FETCH;
         cnt    <= '0;
         pc     <= RESET_PC;
         rtr_pc <= RESET_PC;
      end else begin
         case (phase)
            PH_FETCH, PH_RETIRE: begin
               if (i_ibus_ack)
                  phase <= PH_LOAD;
               else
                  phase <= PH_FETCH;
            end
            PH_LOAD: begin
               cnt   <= '0;
               phase <= PH_RUN;
            end
            default: begin
               cnt <= cnt + 1'b1;
               if (last) begin
                  phase  <= PH_RETIRE;
                  rtr_pc <= pc;
                  pc     <= pc + 32'd4;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_decode #(
   parameter int W = 1
) (
   input  wire          clk,
   input  wire          i_rst_n,
   input  wire   [31:0] i_ibus_rdt,
   input  wire          i_latch,
   input  wire          i_run,
   output logic  [4:0]  o_rs1_addr,
   output logic  [4:0]  o_rs2_addr,
   output logic  [4:0]  o_rd_addr,
   output logic  [2:0]  o_alu_op,
   output logic         o_op_b_imm,
   output logic         o_rd_wen,
   output logic [W-1:0] o_imm
);

   serial_core_pkg::insn_u insn;
   serial_core_pkg::insn_u rdt;
   logic [11:0]            imm_sr;
   logic                   is_op;
   logic                   is_imm;
   logic                   f3_ok;
   logic                   exec;

   assign rdt = i_ibus_rdt;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         insn <= '0;
      else if (i_latch)
         insn <= rdt;
   end

   // Immediate slices, sign bit refills from the top
   always_ff @(posedge clk) begin
      if (i_latch)
         imm_sr <= rdt.i.imm;
      else if (i_run)
         imm_sr <= {{W{imm_sr[11]}}, imm_sr[11:W]};
   end

   assign o_imm = imm_sr[W-1:0];

   always_comb begin
      is_op  = (insn.r.opcode == serial_core_pkg::OPC_OP);
      is_imm = (insn.i.opcode == serial_core_pkg::OPC_OP_IMM);
      f3_ok  = 1'b1;
      case (insn.r.funct3)
         serial_core_pkg::F3_ADD: begin
            // SUB only exists in register form
            if (is_op && insn.r.funct7[5])
               o_alu_op = serial_core_pkg::ALU_SUB;
            else
               o_alu_op = serial_core_pkg::ALU_ADD;
         end
         serial_core_pkg::F3_SLT:  o_alu_op = serial_core_pkg::ALU_SLT;
         serial_core_pkg::F3_SLTU: o_alu_op = serial_core_pkg::ALU_SLTU;
         serial_core_pkg::F3_XOR:  o_alu_op = serial_core_pkg::ALU_XOR;
         serial_core_pkg::F3_OR:   o_alu_op = serial_core_pkg::ALU_OR;
         serial_core_pkg::F3_AND:  o_alu_op = serial_core_pkg::ALU_AND;
         default: begin
            // Shifts are not executed
            o_alu_op = serial_core_pkg::ALU_ADD;
            f3_ok    = 1'b0;
         end
      endcase
      exec = (is_op || is_imm) && f3_ok;
   end

   assign o_rs1_addr = insn.i.rs1;
   assign o_rs2_addr = insn.r.rs2;
   assign o_rd_addr  = exec ? insn.r.rd : 5'd0;
   assign o_op_b_imm = is_imm;
   assign o_rd_wen   = exec;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file #(
   parameter int W = 1
) (
   input  wire          clk,
   input  wire          i_rst_n,
   input  wire          i_load,
   input  wire          i_run,
   input  wire   [4:0]  i_rs1_addr,
   input  wire   [4:0]  i_rs2_addr,
   input  wire   [4:0]  i_rd_addr,
   input  wire          i_rd_wen,
   input  wire  [W-1:0] i_rd_slice,
   input  wire          i_set_lsb,
   output logic [W-1:0] o_rs1,
   output logic [W-1:0] o_rs2,
   output logic [31:0]  o_rtr_rd_data
);

   localparam int XL = serial_core_pkg::XLEN;
   localparam int N  = XL / W;
   localparam int CW = $clog2(N);

   logic [XL-1:0] regs [32];
   logic [XL-1:0] rs1_sr;
   logic [XL-1:0] rs2_sr;
   logic [XL-1:0] res;
   logic [XL-1:0] wdata;
   logic [CW-1:0] cnt;
   logic          last;
   logic          wr;

   assign last = i_run && (cnt == CW'(N - 1));
   assign wr   = i_rd_wen && (i_rd_addr != 5'd0);

   // Compare result lands in bit 0 once the final carry is known
   assign wdata = {i_rd_slice, res[XL-1:W]} | {{(XL-1){1'b0}}, last & i_set_lsb};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         cnt <= '0;
      else if (i_load)
         cnt <= '0;
      else if (i_run)
         cnt <= cnt + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (i_load) begin
         rs1_sr <= (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
         rs2_sr <= (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];
      end else if (i_run) begin
         rs1_sr <= rs1_sr >> W;
         rs2_sr <= rs2_sr >> W;
      end
      if (i_run)
         res <= wdata;
      if (last && wr)
         regs[i_rd_addr] <= wdata;
   end

   assign o_rs1 = rs1_sr[W-1:0];
   assign o_rs2 = rs2_sr[W-1:0];

   // No write means nothing to report
   assign o_rtr_rd_data = wr ? res : '0;

endmodule

`default_nettype wire

// ==== rtl/serial_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module serial_alu #(
   parameter int W = 1
) (
   input  wire          clk,
   input  wire          i_rst_n,
   input  wire          i_run,
   input  wire          i_first,
   input  wire   [2:0]  i_alu_op,
   input  wire          i_op_b_imm,
   input  wire  [W-1:0] i_rs1,
   input  wire  [W-1:0] i_rs2,
   input  wire  [W-1:0] i_imm,
   output logic [W-1:0] o_rd_slice,
   output logic         o_set_lsb
);

   logic [W-1:0] op_b;
   logic [W-1:0] op_b_x;
   logic         inv;
   logic         carry_r;
   logic         cin;
   logic [W:0]   sum;
   logic         lt_s;

   assign op_b   = i_op_b_imm ? i_imm : i_rs2;
   assign inv    = (i_alu_op == serial_core_pkg::ALU_SUB) ||
                   (i_alu_op == serial_core_pkg::ALU_SLT) ||
                   (i_alu_op == serial_core_pkg::ALU_SLTU);
   assign op_b_x = inv ? ~op_b : op_b;
   assign cin    = i_first ? inv : carry_r;
   assign sum    = {1'b0, i_rs1} + {1'b0, op_b_x} + (W + 1)'(cin);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         carry_r <= 1'b0;
      else if (i_run)
         carry_r <= sum[W];
   end

   // Valid on the last slice only, signs differ means rs1 negative wins
   assign lt_s = (i_rs1[W-1] == op_b[W-1]) ? ~sum[W] : i_rs1[W-1];

   always_comb begin
      o_set_lsb = 1'b0;
      case (i_alu_op)
         serial_core_pkg::ALU_AND: o_rd_slice = i_rs1 & op_b;
         serial_core_pkg::ALU_OR:  o_rd_slice = i_rs1 | op_b;
         serial_core_pkg::ALU_XOR: o_rd_slice = i_rs1 ^ op_b;
         serial_core_pkg::ALU_SLT: begin
            o_rd_slice = '0;
            o_set_lsb  = lt_s;
         end
         serial_core_pkg::ALU_SLTU: begin
            o_rd_slice = '0;
            o_set_lsb  = ~sum[W];
         end
         default: o_rd_slice = sum[W-1:0];
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/serial_core_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module serial_core_top #(
   parameter int          W        = 1,
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  wire         clk,
   input  wire         i_rst_n,
   // Instruction bus
   output wire         o_ibus_cyc,
   output wire  [31:0] o_ibus_adr,
   input  wire  [31:0] i_ibus_rdt,
   input  wire         i_ibus_ack,
   // Retire record
   output wire         o_rtr_valid,
   output wire  [31:0] o_rtr_pc,
   output wire  [4:0]  o_rtr_rd_addr,
   output wire  [31:0] o_rtr_rd_data
);

   wire         latch;
   wire         load;
   wire         run;
   wire         first;

   wire [4:0]   rs1_addr;
   wire [4:0]   rs2_addr;
   wire [4:0]   rd_addr;
   wire [2:0]   alu_op;
   wire         op_b_imm;
   wire         rd_wen;
   wire [W-1:0] imm;

   wire [W-1:0] rs1;
   wire [W-1:0] rs2;
   wire [W-1:0] rd_slice;
   wire         set_lsb;

   assign o_rtr_rd_addr = rd_addr;

   core_state #(
      .W        (W),
      .RESET_PC (RESET_PC)
   ) u_state (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ibus_ack  (i_ibus_ack),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_ibus_adr  (o_ibus_adr),
      .o_latch     (latch),
      .o_load      (load),
      .o_run       (run),
      .o_first     (first),
      .o_rtr_valid (o_rtr_valid),
      .o_rtr_pc    (o_rtr_pc)
   );

   inst_decode #(.W(W)) u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_latch    (latch),
      .i_run      (run),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_alu_op   (alu_op),
      .o_op_b_imm (op_b_imm),
      .o_rd_wen   (rd_wen),
      .o_imm      (imm)
   );

   reg_file #(.W(W)) u_rf (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_load        (load),
      .i_run         (run),
      .i_rs1_addr    (rs1_addr),
      .i_rs2_addr    (rs2_addr),
      .i_rd_addr     (rd_addr),
      .i_rd_wen      (rd_wen),
      .i_rd_slice    (rd_slice),
      .i_set_lsb     (set_lsb),
      .o_rs1         (rs1),
      .o_rs2         (rs2),
      .o_rtr_rd_data (o_rtr_rd_data)
   );

   serial_alu #(.W(W)) u_alu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_run      (run),
      .i_first    (first),
      .i_alu_op   (alu_op),
      .i_op_b_imm (op_b_imm),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .o_rd_slice (rd_slice),
      .o_set_lsb  (set_lsb)
   );

endmodule

`default_nettype wire

// ==== dv/tb_prog.svh ====
`ifndef TB_PROG_SVH
`define TB_PROG_SVH

localparam int PROG_LEN = 19;

function automatic logic [31:0] reg_insn(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
   serial_core_pkg::insn_u u;
   u.r = {f7, rs2, rs1, f3, rd, serial_core_pkg::OPC_OP};
   return u;
endfunction

function automatic logic [31:0] imm_insn(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
   serial_core_pkg::insn_u u;
   u.i = {imm, rs1, f3, rd, serial_core_pkg::OPC_OP_IMM};
   return u;
endfunction

// Program word at index idx
// Each source register is written before it is read
function automatic logic [31:0] prog_word(input logic [31:0] idx);
   case (idx)
      0:  return imm_insn(serial_core_pkg::F3_ADD, 5'd1, 5'd0, 12'h7ff);
      1:  return imm_insn(serial_core_pkg::F3_ADD, 5'd2, 5'd0, 12'hfff);
      2:  return imm_insn(serial_core_pkg::F3_ADD, 5'd3, 5'd1, 12'h800);
      3:  return reg_insn(7'h00, serial_core_pkg::F3_ADD, 5'd4, 5'd2, 5'd1);
      4:  return reg_insn(7'h20, serial_core_pkg::F3_ADD, 5'd5, 5'd0, 5'd1);
      5:  return reg_insn(7'h20, serial_core_pkg::F3_ADD, 5'd6, 5'd1, 5'd2);
      6:  return reg_insn(7'h00, serial_core_pkg::F3_AND, 5'd7, 5'd5, 5'd1);
      7:  return reg_insn(7'h00, serial_core_pkg::F3_OR, 5'd8, 5'd6, 5'd1);
      8:  return reg_insn(7'h00, serial_core_pkg::F3_XOR, 5'd9, 5'd5, 5'd2);
      9:  return imm_insn(serial_core_pkg::F3_AND, 5'd10, 5'd5, 12'h0ff);
      10: return imm_insn(serial_core_pkg::F3_OR, 5'd11, 5'd6, 12'hff0);
      11: return imm_insn(serial_core_pkg::F3_XOR, 5'd12, 5'd1, 12'hfff);
      12: return reg_insn(7'h00, serial_core_pkg::F3_SLT, 5'd13, 5'd2, 5'd1);
      13: return reg_insn(7'h00, serial_core_pkg::F3_SLTU, 5'd14, 5'd2, 5'd1);
      14: return imm_insn(serial_core_pkg::F3_SLT, 5'd15, 5'd1, 12'h800);
      15: return imm_insn(serial_core_pkg::F3_SLTU, 5'd16, 5'd1, 12'hfff);
      16: return imm_insn(serial_core_pkg::F3_ADD, 5'd0, 5'd1, 12'h005);
      // LUI x1 with an ADD funct3 field is not executed
      17: return 32'h0dea80b7;
      18: return reg_insn(7'h00, serial_core_pkg::F3_ADD, 5'd17, 5'd0, 5'd1);
      default: return 32'h0000_0013;
   endcase
endfunction

// Retire record {rd, data} from the RV32I rules for OP and OP-IMM
function automatic logic [36:0] predict_retire(input logic [31:0] word,
                                               input logic [31:0] a,
                                               input logic [31:0] b_reg);
   serial_core_pkg::insn_u in;
   logic [31:0]            b;
   logic [31:0]            res;
   logic                   is_op;
   logic                   ok;
   in    = word;
   is_op = (in.r.opcode == serial_core_pkg::OPC_OP);
   ok    = is_op || (in.i.opcode == serial_core_pkg::OPC_OP_IMM);
   b     = is_op ? b_reg : {{20{in.i.imm[11]}}, in.i.imm};
   case (in.r.funct3)
      serial_core_pkg::F3_ADD:  res = (is_op && in.r.funct7 == 7'h20) ? a - b : a + b;
      serial_core_pkg::F3_SLT:  res = {31'd0, $signed(a) < $signed(b)};
      serial_core_pkg::F3_SLTU: res = {31'd0, a < b};
      serial_core_pkg::F3_XOR:  res = a ^ b;
      serial_core_pkg::F3_OR:   res = a | b;
      serial_core_pkg::F3_AND:  res = a & b;
      default: begin
         res = 32'd0;
         ok  = 1'b0;
      end
   endcase
   if (!ok || in.r.rd == 5'd0)
      return 37'd0;
   return {in.r.rd, res};
endfunction

`endif

// ==== dv/tb_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_top;

   `include "tb_prog.svh"

   localparam int          W        = 4;
   localparam logic [31:0] RESET_PC = 32'h0000_1000;
   localparam int          N        = 32 / W;
   localparam int          TIMEOUT  = PROG_LEN * (N + 2 + 4) + 50;

   logic        clk      = 1'b0;
   logic        rst_n    = 1'b0;
   logic [31:0] ibus_rdt = 32'd0;
   logic        ibus_ack = 1'b0;
   wire         ibus_cyc;
   wire  [31:0] ibus_adr;
   wire         rtr_valid;
   wire  [31:0] rtr_pc;
   wire  [4:0]  rtr_rd_addr;
   wire  [31:0] rtr_rd_data;

   logic [31:0]            lcg_state;
   logic                   busy;
   logic [1:0]             wait_cnt;
   serial_core_pkg::insn_u cur_insn;
   logic [31:0]            ref_regs [32];
   logic [31:0]            fetch_pc;
   logic [31:0]            exp_pc;
   logic [4:0]             exp_rd;
   logic [31:0]            exp_data;
   logic                   pending;
   logic                   ack_d;
   int                     age;
   int                     retired;
   int                     cycles = 0;
   int                     errors = 0;

   serial_core_top #(
      .W        (W),
      .RESET_PC (RESET_PC)
   ) serial_core_top_inst (
      .clk           (clk),
      .i_rst_n       (rst_n),
      .o_ibus_cyc    (ibus_cyc),
      .o_ibus_adr    (ibus_adr),
      .i_ibus_rdt    (ibus_rdt),
      .i_ibus_ack    (ibus_ack),
      .o_rtr_valid   (rtr_valid),
      .o_rtr_pc      (rtr_pc),
      .o_rtr_rd_addr (rtr_rd_addr),
      .o_rtr_rd_data (rtr_rd_data)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Instruction memory, 0 to 3 wait cycles before ack
   always @(posedge clk) begin
      if (!rst_n) begin
         ibus_ack  <= 1'b0;
         busy      <= 1'b0;
         wait_cnt  <= 2'd0;
         lcg_state <= 32'h839b_6b9c;
      end else begin
         ibus_ack <= 1'b0;
         if (busy && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else if (busy) begin
            busy     <= 1'b0;
            ibus_ack <= 1'b1;
            ibus_rdt <= prog_word((ibus_adr - RESET_PC) >> 2);
         end else if (ibus_cyc && !ibus_ack && (ibus_adr - RESET_PC) < 32'(PROG_LEN * 4)) begin
            lcg_state <= lcg_step(lcg_state);
            busy      <= 1'b1;
            wait_cnt  <= lcg_state[31:30];
         end
      end
   end

   always_comb begin
      {exp_rd, exp_data} = predict_retire(cur_insn, ref_regs[cur_insn.r.rs1],
                                          ref_regs[cur_insn.r.rs2]);
   end

   // Reference state, follows each ack and each retire
   always @(posedge clk) begin
      if (!rst_n) begin
         fetch_pc <= RESET_PC;
         exp_pc   <= RESET_PC;
         cur_insn <= '0;
         pending  <= 1'b0;
         ack_d    <= 1'b0;
         age      <= 0;
         retired  <= 0;
         for (int i = 0; i < 32; i++)
            ref_regs[i] <= 32'd0;
      end else begin
         cycles <= cycles + 1;
         ack_d  <= ibus_cyc && ibus_ack;
         age    <= age + 1;
         if (ibus_cyc && ibus_ack) begin
            cur_insn <= ibus_rdt;
            fetch_pc <= fetch_pc + 32'd4;
            pending  <= 1'b1;
            age      <= 1;
         end else if (rtr_valid) begin
            pending <= 1'b0;
         end
         if (rtr_valid) begin
            exp_pc  <= exp_pc + 32'd4;
            retired <= retired + 1;
            if (exp_rd != 5'd0)
               ref_regs[exp_rd] <= exp_data;
         end
      end
   end

   fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
      (ibus_cyc && ibus_ack) |-> (ibus_adr == fetch_pc))
      else begin
         errors++;
         $display("Error o_ibus_adr expected %08h got %08h", $sampled(fetch_pc),
                  $sampled(ibus_adr));
      end

   cyc_drop: assert property (@(posedge clk) disable iff (!rst_n) ack_d |-> !ibus_cyc)
      else begin
         errors++;
         $display("o_ibus_cyc stayed high in the cycle after ack");
      end

   retire_late: assert property (@(posedge clk) disable iff (!rst_n)
      rtr_valid |-> (pending && age == N + 2))
      else begin
         errors++;
         $display("Retire pulse not N+2 cycles after its ack");
      end

   retire_missing: assert property (@(posedge clk) disable iff (!rst_n)
      (pending && age == N + 2) |-> rtr_valid)
      else begin
         errors++;
         $display("No retire pulse N+2 cycles after ack");
      end

   retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
      rtr_valid |-> (rtr_pc == exp_pc))
      else begin
         errors++;
         $display("Error o_rtr_pc expected %08h got %08h", $sampled(exp_pc), $sampled(rtr_pc));
      end

   retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
      rtr_valid |-> (rtr_rd_addr == exp_rd))
      else begin
         errors++;
         $display("Error o_rtr_rd_addr expected %02h got %02h", $sampled(exp_rd),
                  $sampled(rtr_rd_addr));
      end

   retire_data: assert property (@(posedge clk) disable iff (!rst_n)
      rtr_valid |-> (rtr_rd_data == exp_data))
      else begin
         errors++;
         $display("Error o_rtr_rd_data expected %08h got %08h", $sampled(exp_data),
                  $sampled(rtr_rd_data));
      end

   initial begin
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      while (retired < PROG_LEN && cycles < TIMEOUT)
         @(posedge clk);
      @(posedge clk);
      if (retired < PROG_LEN) begin
         errors++;
         $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                  cycles, retired, PROG_LEN);
      end
      $display("Retired %0d instructions, %0d errors", retired, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
rtl/serial_core_pkg.sv
rtl/core_state.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/serial_alu.sv
rtl/serial_core_top.sv
dv/tb_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_top -Mdir obj_dir
	out="$$(./obj_dir/Vtb_top)"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
